//--- rtl/lsuPkg.sv
`default_nettype none

package lsuPkg;

    // byte address as seen by the core.
    typedef logic [31:0] addrT;

    // load/store data word.
    typedef logic [31:0] dataT;

    typedef logic [2:0] lenT;  // access size in bytes, 1, 2 or 4.

    typedef logic [3:0] tagT;  // names the result.

    // byte-serial memory controller states.
    typedef enum logic [1:0] {
        idle,
        access,
        finish
    } mcStateT;

endpackage

`default_nettype wire

//--- rtl/loadStoreQueue.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreQueue #(
    parameter int queueDepth = 4
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         issue,
    input  logic         issueStore,
    input  lsuPkg::addrT issueAddr,
    input  lsuPkg::dataT issueData,
    input  lsuPkg::lenT  issueLen,
    input  lsuPkg::tagT  issueTag,
    input  logic         slotFree,
    output logic         issueReady,
    output logic         pop,
    output logic         popStore,
    output lsuPkg::addrT popAddr,
    output lsuPkg::dataT popData,
    output lsuPkg::lenT  popLen,
    output lsuPkg::tagT  popTag
);
    import lsuPkg::*;

    localparam int ptrBits = (queueDepth > 1) ? $clog2(queueDepth) : 1;
    localparam int cntBits = $clog2(queueDepth + 1);
    localparam logic [ptrBits-1:0] lastPtr = ptrBits'(queueDepth - 1);
    localparam logic [cntBits-1:0] fullCount = cntBits'(queueDepth);

    logic storeQ [queueDepth];
    addrT addrQ [queueDepth];
    dataT dataQ [queueDepth];
    lenT  lenQ [queueDepth];
    tagT  tagQ [queueDepth];

    logic [ptrBits-1:0] rdPtr;
    logic [ptrBits-1:0] wrPtr;
    logic [cntBits-1:0] count;
    logic               push;

    // pointers wrap at the depth, which need not be a power of two.
    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        if (ptr == lastPtr) begin
            return '0;
        end
        return ptr + ptrBits'(1);
    endfunction

    assign issueReady = (count != fullCount);  // not full.
    assign push       = issue && issueReady;
    assign pop        = (count != '0) && slotFree;

    assign popStore = storeQ[rdPtr];
    assign popAddr  = addrQ[rdPtr];
    assign popData  = dataQ[rdPtr];
    assign popLen   = lenQ[rdPtr];
    assign popTag   = tagQ[rdPtr];

    always_ff @(posedge clk) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (rdy) begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (push && !pop) begin
                count <= count + cntBits'(1);
            end else if (pop && !push) begin
                count <= count - cntBits'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && push) begin
            storeQ[wrPtr] <= issueStore;
            addrQ[wrPtr]  <= issueAddr;
            dataQ[wrPtr]  <= issueData;
            lenQ[wrPtr]   <= issueLen;
            tagQ[wrPtr]   <= issueTag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/requestSlot.sv
`timescale 1ns/1ps
`default_nettype none

module requestSlot (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         pop,
    input  logic         popStore,
    input  lsuPkg::addrT popAddr,
    input  lsuPkg::dataT popData,
    input  lsuPkg::lenT  popLen,
    input  lsuPkg::tagT  popTag,
    input  logic         memDone,
    input  lsuPkg::dataT memLoadData,
    output logic         slotFree,
    output logic         memRequest,
    output logic         memStore,
    output lsuPkg::addrT memAddr,
    output lsuPkg::dataT memData,
    output lsuPkg::lenT  memLen,
    output logic         done,
    output lsuPkg::dataT doneData,
    output lsuPkg::tagT  doneTag
);
    import lsuPkg::*;

    logic occupied;
    logic heldStore;
    addrT heldAddr;
    dataT heldData;
    lenT  heldLen;
    tagT  heldTag;

    // free while held in reset, so the queue sees an open slot right away.
    assign slotFree = rst || (rdy && !occupied);

    assign memRequest = occupied && rdy;
    assign memStore   = heldStore;
    assign memAddr    = heldAddr;
    assign memData    = heldData;
    assign memLen     = heldLen;

    assign done     = occupied && memDone;  // one-cycle result.
    assign doneData = memLoadData;
    assign doneTag  = heldTag;

    always_ff @(posedge clk) begin
        if (rst) begin
            occupied <= 1'b0;
        end else if (rdy) begin
            if (memDone) begin
                occupied <= 1'b0;
            end
            if (pop) begin
                occupied <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && pop) begin
            heldStore <= popStore;
            heldAddr  <= popAddr;
            heldData  <= popData;
            heldLen   <= popLen;
            heldTag   <= popTag;
        end
    end

endmodule

`default_nettype wire

//--- rtl/memController.sv
`timescale 1ns/1ps
`default_nettype none

module memController #(
    parameter int ramAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   memRequest,
    input  logic                   memStore,
    input  lsuPkg::addrT           memAddr,
    input  lsuPkg::dataT           memData,
    input  lsuPkg::lenT            memLen,
    input  logic [7:0]             ramReadData,
    output logic                   memDone,
    output lsuPkg::dataT           memLoadData,
    output logic                   ramWrite,
    output logic [ramAddrBits-1:0] ramAddr,
    output logic [7:0]             ramWriteData
);
    import lsuPkg::*;

    mcStateT state;

    logic                   heldStore;
    logic [ramAddrBits-1:0] heldAddr;
    dataT                   heldData;
    lenT                    heldLen;
    dataT                   loadData;

    logic [1:0] byteIdx;
    logic [1:0] lastIdx;
    logic [1:0] prevIdx;    // byte the RAM sampled on the last edge.
    logic       prevValid;

    assign lastIdx = 2'(heldLen - lenT'(1));

    // address stays on the last byte in finish so the read data holds.
    assign ramAddr      = heldAddr + ramAddrBits'(byteIdx);
    assign ramWrite     = rdy && (state == access) && heldStore;
    assign ramWriteData = heldData[{byteIdx, 3'b000} +: 8];
    assign memDone      = rdy && (state == finish);

    // last byte is still on the RAM output, merged in here.
    always_comb begin
        memLoadData = '0;
        if (!heldStore) begin
            memLoadData = loadData;
            memLoadData[{lastIdx, 3'b000} +: 8] = ramReadData;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= idle;
            byteIdx <= '0;
        end else if (rdy) begin
            case (state)
                idle: begin
                    if (memRequest) begin
                        byteIdx <= '0;
                        state   <= access;
                    end
                end
                access: begin
                    if (byteIdx == lastIdx) begin
                        state <= finish;
                    end else begin
                        byteIdx <= byteIdx + 2'd1;  // little-endian walk.
                    end
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    // the RAM reads on every clock, so tracking follows the clock too.
    always_ff @(posedge clk) begin
        if (rst) begin
            prevValid <= 1'b0;
            prevIdx   <= '0;
        end else begin
            prevValid <= (state == access);
            prevIdx   <= byteIdx;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && (state == idle) && memRequest) begin
            heldStore <= memStore;
            heldAddr  <= memAddr[ramAddrBits-1:0];
            heldData  <= memData;
            heldLen   <= memLen;
            loadData  <= '0;  // zero-extend short loads.
        end else if (prevValid && !heldStore) begin
            loadData[{prevIdx, 3'b000} +: 8] <= ramReadData;
        end
    end

endmodule

`default_nettype wire

//--- rtl/dataRam.sv
`timescale 1ns/1ps
`default_nettype none

module dataRam #(
    parameter int ramAddrBits = 10
) (
    input  logic                   clk,
    input  logic                   ramWrite,
    input  logic [ramAddrBits-1:0] ramAddr,
    input  logic [7:0]             ramWriteData,
    output logic [7:0]             ramReadData
);
    localparam int ramBytes = 1 << ramAddrBits;

    logic [7:0] mem [ramBytes];

    always_ff @(posedge clk) begin
        if (ramWrite) begin
            mem[ramAddr] <= ramWriteData;
        end
    end

    // registered read, one cycle after the address. read-before-write.
    always_ff @(posedge clk) begin
        ramReadData <= mem[ramAddr];
    end

endmodule

`default_nettype wire

//--- rtl/loadStoreUnit.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit #(
    parameter int queueDepth  = 4,
    parameter int ramAddrBits = 10
) (
    input  logic         clk,
    input  logic         rst,
    input  logic         rdy,
    input  logic         issue,
    input  logic         issueStore,
    input  lsuPkg::addrT issueAddr,
    input  lsuPkg::dataT issueData,
    input  lsuPkg::lenT  issueLen,
    input  lsuPkg::tagT  issueTag,
    output logic         issueReady,
    output logic         done,
    output lsuPkg::dataT doneData,
    output lsuPkg::tagT  doneTag
);
    import lsuPkg::*;

    // queue to slot.
    logic slotFree;
    logic pop;
    logic popStore;
    addrT popAddr;
    dataT popData;
    lenT  popLen;
    tagT  popTag;

    // slot to controller.
    logic memRequest;
    logic memStore;
    addrT memAddr;
    dataT memData;
    lenT  memLen;
    logic memDone;
    dataT memLoadData;

    logic                   ramWrite;
    logic [ramAddrBits-1:0] ramAddr;
    logic [7:0]             ramWriteData;
    logic [7:0]             ramReadData;

    loadStoreQueue #(
        .queueDepth(queueDepth)
    ) lsQueue (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issue(issue), .issueStore(issueStore), .issueAddr(issueAddr),
        .issueData(issueData), .issueLen(issueLen), .issueTag(issueTag),
        .slotFree(slotFree), .issueReady(issueReady), .pop(pop),
        .popStore(popStore), .popAddr(popAddr), .popData(popData),
        .popLen(popLen), .popTag(popTag)
    );

    requestSlot reqSlot (
        .clk(clk), .rst(rst), .rdy(rdy),
        .pop(pop), .popStore(popStore), .popAddr(popAddr), .popData(popData),
        .popLen(popLen), .popTag(popTag),
        .memDone(memDone), .memLoadData(memLoadData), .slotFree(slotFree),
        .memRequest(memRequest), .memStore(memStore), .memAddr(memAddr),
        .memData(memData), .memLen(memLen),
        .done(done), .doneData(doneData), .doneTag(doneTag)
    );

    memController #(
        .ramAddrBits(ramAddrBits)
    ) memCtrl (
        .clk(clk), .rst(rst), .rdy(rdy),
        .memRequest(memRequest), .memStore(memStore), .memAddr(memAddr),
        .memData(memData), .memLen(memLen), .ramReadData(ramReadData),
        .memDone(memDone), .memLoadData(memLoadData),
        .ramWrite(ramWrite), .ramAddr(ramAddr), .ramWriteData(ramWriteData)
    );

    dataRam #(
        .ramAddrBits(ramAddrBits)
    ) ram (
        .clk(clk),
        .ramWrite(ramWrite),
        .ramAddr(ramAddr),
        .ramWriteData(ramWriteData),
        .ramReadData(ramReadData)
    );

endmodule

`default_nettype wire

//--- sim/loadStoreUnit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit_checker (
    input logic clk,
    input logic rst,
    input logic rdy,
    input logic issue,
    input logic issueReady,
    input logic pop,
    input logic slotFree,
    input logic done
);

    // a stalled design produces no result.
    doneOnlyWithRdy: assert property (@(posedge clk) disable iff (rst) done |-> rdy)
        else $error("done raised while rdy is low");

    doneSingleCycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done high for two cycles in a row");

    issueOnlyWhenReady: assert property (@(posedge clk) disable iff (rst)
        issue |-> issueReady)
        else $error("issue while the queue is full");

    // the queue hands over only into an open slot, which then fills.
    popOnlyWhenFree: assert property (@(posedge clk) disable iff (rst)
        pop |-> slotFree ##1 !slotFree)
        else $error("pop while the slot is busy, or the slot did not take it");

endmodule

bind loadStoreUnit loadStoreUnit_checker i_checker (
    .clk(clk),
    .rst(rst),
    .rdy(rdy),
    .issue(issue),
    .issueReady(issueReady),
    .pop(pop),
    .slotFree(slotFree),
    .done(done)
);

`default_nettype wire

//--- sim/loadStoreUnit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit_tb;
    import lsuPkg::*;

    localparam int queueDepth     = 4;
    localparam int ramAddrBits    = 10;
    localparam int clockPeriod    = 100;
    localparam int numLines       = 22;  // requests in the golden file.
    localparam int fieldsPerLine  = 6;
    localparam int watchdogCycles = numLines * (queueDepth + 8) * 4;

    logic clk;
    logic rst;
    logic rdy;
    logic issue;
    logic issueStore;
    addrT issueAddr;
    dataT issueData;
    lenT  issueLen;
    tagT  issueTag;
    logic issueReady;
    logic done;
    dataT doneData;
    tagT  doneTag;

    logic [31:0] golden [numLines * fieldsPerLine];
    tagT         expTag[$];
    dataT        expData[$];

    integer seed        = 32'h966346a1;
    logic   stallsOn    = 1'b0;
    logic   sawFull     = 1'b0;
    logic   doneLast    = 1'b0;
    logic   popLast     = 1'b0;
    int     valueErrors = 0;
    int     otherErrors = 0;

    loadStoreUnit #(
        .queueDepth(queueDepth),
        .ramAddrBits(ramAddrBits)
    ) i_dut (
        .clk(clk), .rst(rst), .rdy(rdy),
        .issue(issue), .issueStore(issueStore), .issueAddr(issueAddr),
        .issueData(issueData), .issueLen(issueLen), .issueTag(issueTag),
        .issueReady(issueReady), .done(done), .doneData(doneData), .doneTag(doneTag)
    );

    initial begin
        clk = 1'b0;
        forever #(clockPeriod / 2) clk = ~clk;
    end

    // drop rdy about one cycle in four.
    initial begin
        forever begin
            @(posedge clk);
            if (stallsOn) begin
                rdy <= (($random(seed) & 3) != 0);
            end else begin
                rdy <= 1'b1;
            end
        end
    end

    task automatic checkTag(input tagT got, input tagT want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
            valueErrors++;
        end
    endtask

    task automatic checkData(input dataT got, input dataT want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, want);
            valueErrors++;
        end
    endtask

    task automatic checkLevel(input logic got, input logic want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s is %b, expected %b", $time, what, got, want);
            valueErrors++;
        end
    endtask

    task automatic driveLine(input int line);
        int base;
        base = line * fieldsPerLine;
        issueStore <= golden[base][0];
        issueAddr  <= golden[base + 1];
        issueData  <= golden[base + 2];
        issueLen   <= lenT'(golden[base + 3]);
        issueTag   <= tagT'(golden[base + 4]);
        issue      <= 1'b1;
    endtask

    // one pass over the golden file.
    task automatic runGolden();
        int   line;
        logic heldNow;
        logic readyNow;
        logic takenNow;
        line = 0;
        while (line < numLines) begin
            @(negedge clk);
            heldNow  = issue;
            readyNow = issueReady;
            takenNow = issue && issueReady && rdy;
            @(posedge clk);
            if (takenNow) begin
                expTag.push_back(tagT'(golden[line * fieldsPerLine + 4]));
                expData.push_back(golden[line * fieldsPerLine + 5]);
                line = line + 1;
                // queue holds no more than the results still outstanding.
                if (line < numLines && expTag.size() < queueDepth) begin
                    driveLine(line);
                end else begin
                    issue <= 1'b0;
                end
            end else if (heldNow || readyNow) begin
                driveLine(line);
            end
        end
    endtask

    task automatic waitDrained();
        while (expTag.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic finishRun();
        $display("errors: %0d wrong values, %0d other failures", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    endtask

    // results and protocol, sampled mid-cycle.
    initial begin
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (!issueReady) begin
                    sawFull = 1'b1;
                end
                if (done && !rdy) begin
                    $display("done was raised at %0t while rdy was low", $time);
                    otherErrors++;
                end
                if (done && doneLast) begin
                    $display("done stayed high for two cycles at %0t", $time);
                    otherErrors++;
                end
                if (issue && !issueReady) begin
                    $display("a request was issued into a full queue at %0t", $time);
                    otherErrors++;
                end
                if (popLast && i_dut.slotFree) begin
                    $display("the slot stayed free after a pop at %0t", $time);
                    otherErrors++;
                end
                if (done) begin
                    if (expTag.size() == 0) begin
                        $display("a result came back at %0t with no request outstanding",
                                 $time);
                        otherErrors++;
                    end else begin
                        checkTag(doneTag, expTag.pop_front(), "result tag");
                        checkData(doneData, expData.pop_front(), "result data");
                    end
                end
                doneLast = done;
                popLast  = i_dut.pop;
            end
        end
    end

    initial begin
        repeat (watchdogCycles) @(posedge clk);
        $display("timeout: results still missing after %0d cycles", watchdogCycles);
        otherErrors++;
        finishRun();
    end

    initial begin
        rst        = 1'b1;
        rdy        = 1'b1;
        issue      = 1'b0;
        issueStore = 1'b0;
        issueAddr  = '0;
        issueData  = '0;
        issueLen   = '0;
        issueTag   = '0;
        $readmemh("sim/lsu_golden.txt", golden);
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkLevel(done, 1'b0, "done after reset");
        checkLevel(issueReady, 1'b1, "issueReady after reset");
        runGolden();
        waitDrained();
        stallsOn = 1'b1;  // same requests again under stalls.
        runGolden();
        waitDrained();
        stallsOn = 1'b0;
        if (!sawFull) begin
            $display("issueReady never dropped, so the queue was never filled");
            otherErrors++;
        end
        finishRun();
    end

endmodule

`default_nettype wire

//--- sim/lsu_golden.txt
// columns: store flag, address, data, length in bytes, tag, expected result data
// all values hex, one request per line; stores expect zero
1 00000100 DEADBEEF 4 1 00000000
0 00000100 00000000 4 2 DEADBEEF
1 00000104 11223344 4 3 00000000
1 00000104 000000AA 1 4 00000000
1 00000106 0000BBCC 2 5 00000000
0 00000104 00000000 4 6 BBCC33AA
0 00000105 00000000 1 7 00000033
0 00000106 00000000 2 8 0000BBCC
0 00000107 00000000 1 9 000000BB
1 00000101 FFFFFF55 1 A 00000000
0 00000100 00000000 4 B DEAD55EF
0 00000102 00000000 2 C 0000DEAD
1 00000200 01020304 4 D 00000000
1 00000204 A5A55A5A 4 E 00000000
1 00000208 CAFEF00D 4 F 00000000
0 00000200 00000000 4 0 01020304
0 00000204 00000000 4 1 A5A55A5A
0 00000208 00000000 4 2 CAFEF00D
0 0000020B 00000000 1 3 000000CA
0 00000208 00000000 2 4 0000F00D
1 0000020A 12345678 2 5 00000000
0 00000208 00000000 4 6 5678F00D

//--- loadStoreUnit.f
rtl/lsuPkg.sv
rtl/loadStoreQueue.sv
rtl/requestSlot.sv
rtl/memController.sv
rtl/dataRam.sv
rtl/loadStoreUnit.sv
sim/loadStoreUnit_checker.sv
sim/loadStoreUnit_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := loadStoreUnit_tb
FILELIST := loadStoreUnit.f
BUILDDIR := obj_dir
LOG      := sim.log
PASSMSG  := Everything OK

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) > $(LOG) 2>&1 ; cat $(LOG)
	@grep -qx "$(PASSMSG)" $(LOG) && echo "test passed" || (echo "test failed"; exit 1)

clean:
	rm -rf $(BUILDDIR) $(LOG)
